//--- booth_mult.f
verilog/mult_pkg.sv
verilog/booth.sv
verilog/pp_stage.sv
verilog/pp_fifo.sv
verilog/dadda_tree.sv
verilog/product_stage.sv
verilog/booth_mult.sv
bench/tb_booth_mult.sv

//--- Makefile
SIM        = verilator
LINT_FLAGS = --lint-only -Wall -Wno-fatal --timing
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
TOP        = tb_booth_mult
RTL_TOP    = booth_mult
FILELIST   = booth_mult.f
PASS_MSG   = Finished with no errors
OBJ_DIR    = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- bench/tb_booth_mult.sv
module tb_booth_mult
	import mult_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int WAIT_LIMIT = 200;    // cycles any single wait may take
	localparam int STREAM_LEN = 8;
	localparam int BP_PAIRS   = 200;

	logic     clk;
	logic     arst_n;
	operand_t a_in;
	operand_t b_in;
	logic     in_valid;
	logic     in_ready;
	product_t product;
	logic     out_valid;
	logic     out_ready;

	operand_t    exp_a [$];           // pairs accepted and not yet multiplied
	operand_t    exp_b [$];
	int          out_cycles [$];      // cycle of each output transfer
	logic [15:0] lfsr;
	int          cycle     = 0;
	int          errors    = 0;
	int          timeouts  = 0;
	int          delivered = 0;
	logic        in_fire   = 1'b0;    // input transfer at the coming edge
	logic        stalled   = 1'b0;
	product_t    held;

	booth_mult dut (
		.clk       (clk),
		.arst_n    (arst_n),
		.a_in      (a_in),
		.b_in      (b_in),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.product   (product),
		.out_valid (out_valid),
		.out_ready (out_ready)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) cycle++;

	task automatic check_product(input product_t got, input product_t exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("ERROR %0t: %s expected %0d got %0d", $time, what, exp, got);
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("ERROR %0t: %s expected %b got %b", $time, what, exp, got);
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp) begin
			errors++;
			$display("ERROR %0t: %s expected %0d got %0d", $time, what, exp, got);
		end
	endtask

	// taps for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic rand_bit();
		logic fb;
		fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic operand_t rand_operand();
		operand_t v;
		for (int i = 0; i < OP_W; i++)
			v[i] = rand_bit();
		return v;
	endfunction

	// sampled mid-cycle away from the drive point
	always @(negedge clk) begin
		operand_t a;
		operand_t b;
		in_fire = in_valid && in_ready && arst_n;
		if (in_fire) begin
			exp_a.push_back(a_in);
			exp_b.push_back(b_in);
		end
		if (stalled) begin
			check_bit(out_valid, 1'b1, "out_valid while stalled");
			check_product(product, held, "product while stalled");
		end
		stalled = out_valid && !out_ready;
		held    = product;
		if (out_valid && out_ready) begin
			out_cycles.push_back(cycle);
			delivered++;
			if (exp_a.size() == 0) begin
				errors++;
				$display("product %0d came out with no pair waiting, at %0t", product, $time);
			end else begin
				a = exp_a.pop_front();
				b = exp_b.pop_front();
				check_product(product, product_t'(a) * product_t'(b),
					$sformatf("product of %0d and %0d", a, b));
			end
		end
	end

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic send_pair(input operand_t a, input operand_t b);
		int n;
		n        = 0;
		a_in     = a;
		b_in     = b;
		in_valid = 1'b1;
		do begin
			next_cycle();
			n++;
		end while (!in_fire && n < WAIT_LIMIT);
		if (!in_fire) begin
			timeouts++;
			$display("timeout: pair %0d x %0d was never accepted", a, b);
		end
		in_valid = 1'b0;
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (exp_a.size() != 0 && n < WAIT_LIMIT) begin
			next_cycle();
			n++;
		end
		if (exp_a.size() != 0) begin
			timeouts++;
			$display("timeout: %0d products never came out", exp_a.size());
		end
	endtask

	task automatic test_reset();
		repeat (5) begin
			@(negedge clk);
			check_bit(out_valid, 1'b0, "out_valid in reset");
			check_bit(in_ready, 1'b1, "in_ready in reset");
		end
		next_cycle();
		arst_n = 1'b1;
		@(negedge clk);
		check_bit(out_valid, 1'b0, "out_valid after reset");
		check_bit(in_ready, 1'b1, "in_ready after reset");
		next_cycle();
	endtask

	task automatic test_corners();
		operand_t vals [5] = '{10'd0, 10'd1, 10'd511, 10'd512, 10'd1023};
		foreach (vals[i])
			foreach (vals[j])
				send_pair(vals[i], vals[j]);
		wait_drain();
	endtask

	task automatic test_booth_digits();
		operand_t mults [$];
		operand_t cands [4] = '{10'd1, 10'h3ff, 10'h2aa, 10'h133};
		operand_t b;
		mults = '{10'h2aa, 10'h155, 10'h3ff};
		for (int g = 0; g < PP_ROWS; g++) begin
			for (int c = 0; c < 8; c++) begin
				if (g == 0 && c[0])
					continue;             // bit below group 0 is always zero
				b        = '0;
				b[2*g+1] = c[2];
				b[2*g]   = c[1];
				if (g > 0)
					b[2*g-1] = c[0];
				mults.push_back(b);
			end
		end
		foreach (mults[i])
			foreach (cands[j])
				send_pair(cands[j], mults[i]);
		wait_drain();
	endtask

	task automatic test_latency();
		int n;
		int start;
		int first;
		out_ready = 1'b1;
		send_pair(10'd37, 10'd701);
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!out_valid && n < WAIT_LIMIT);
		if (!out_valid) begin
			timeouts++;
			$display("timeout: out_valid never rose for the single pair");
		end
		check_count(n, 3, "edges from accept to out_valid");
		next_cycle();
		wait_drain();
		start = cycle;
		first = out_cycles.size();
		for (int i = 0; i < STREAM_LEN; i++)
			send_pair(rand_operand(), rand_operand());
		check_count(cycle - start, STREAM_LEN, "cycles to accept the stream");
		wait_drain();
		if (out_cycles.size() >= first + STREAM_LEN)
			check_count(out_cycles[first+STREAM_LEN-1] - out_cycles[first], STREAM_LEN - 1,
				"cycles from first to last streamed product");
	endtask

	task automatic test_backpressure();
		int sent;
		int n;
		int base;
		sent = 0;
		n    = 0;
		base = delivered;
		while (sent < BP_PAIRS && n < BP_PAIRS * 20) begin
			if (in_valid && in_fire) begin
				sent++;
				in_valid = 1'b0;
			end
			if (!in_valid && sent < BP_PAIRS && rand_bit()) begin
				a_in     = rand_operand();
				b_in     = rand_operand();
				in_valid = 1'b1;              // held until taken
			end
			out_ready = rand_bit();
			next_cycle();
			n++;
		end
		if (sent < BP_PAIRS) begin
			timeouts++;
			$display("timeout: only %0d of %0d stalled pairs were accepted", sent, BP_PAIRS);
		end
		in_valid  = 1'b0;
		out_ready = 1'b1;
		wait_drain();
		check_count(delivered - base, sent, "products out of the stalled stream");
	endtask

	initial begin
		arst_n    = 1'b0;
		a_in      = '0;
		b_in      = '0;
		in_valid  = 1'b0;
		out_ready = 1'b1;
		lfsr      = 16'd16791;
		test_reset();
		test_corners();
		test_booth_digits();
		test_latency();
		test_backpressure();
		$display("checks done: %0d mismatches, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

//--- verilog/booth_mult.sv
module booth_mult
	import mult_pkg::*;
(
	input  logic     clk,
	input  logic     arst_n,
	input  operand_t a_in,
	input  operand_t b_in,
	input  logic     in_valid,
	output logic     in_ready,
	output product_t product,
	output logic     out_valid,
	input  logic     out_ready
);

	logic     pp_valid, pp_ready;
	pp_t      pp1, pp2, pp3, pp4, pp5;
	pp_last_t pp6;
	signs_t   signs;

	logic     q_valid, q_ready;
	pp_t      q_pp1, q_pp2, q_pp3, q_pp4, q_pp5;
	pp_last_t q_pp6;
	signs_t   q_signs;

	pp_stage u_pp_stage (
		.clk      (clk),
		.arst_n   (arst_n),
		.a_in     (a_in),
		.b_in     (b_in),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.pp_valid (pp_valid),
		.pp_ready (pp_ready),
		.pp1      (pp1),
		.pp2      (pp2),
		.pp3      (pp3),
		.pp4      (pp4),
		.pp5      (pp5),
		.pp6      (pp6),
		.signs    (signs)
	);

	pp_fifo u_pp_fifo (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (pp_valid),
		.in_ready  (pp_ready),
		.in_pp1    (pp1),
		.in_pp2    (pp2),
		.in_pp3    (pp3),
		.in_pp4    (pp4),
		.in_pp5    (pp5),
		.in_pp6    (pp6),
		.in_signs  (signs),
		.out_valid (q_valid),
		.out_ready (q_ready),
		.out_pp1   (q_pp1),
		.out_pp2   (q_pp2),
		.out_pp3   (q_pp3),
		.out_pp4   (q_pp4),
		.out_pp5   (q_pp5),
		.out_pp6   (q_pp6),
		.out_signs (q_signs)
	);

	product_stage u_product_stage (
		.clk       (clk),
		.arst_n    (arst_n),
		.q_valid   (q_valid),
		.q_ready   (q_ready),
		.q_pp1     (q_pp1),
		.q_pp2     (q_pp2),
		.q_pp3     (q_pp3),
		.q_pp4     (q_pp4),
		.q_pp5     (q_pp5),
		.q_pp6     (q_pp6),
		.q_signs   (q_signs),
		.product   (product),
		.out_valid (out_valid),
		.out_ready (out_ready)
	);

endmodule

//--- verilog/product_stage.sv
module product_stage
	import mult_pkg::*;
(
	input  logic     clk,
	input  logic     arst_n,
	input  logic     q_valid,
	output logic     q_ready,
	input  pp_t      q_pp1,
	input  pp_t      q_pp2,
	input  pp_t      q_pp3,
	input  pp_t      q_pp4,
	input  pp_t      q_pp5,
	input  pp_last_t q_pp6,
	input  signs_t   q_signs,
	output product_t product,
	output logic     out_valid,
	input  logic     out_ready
);

	product_t sum_row;
	product_t carry_row;
	logic     take;

	dadda_tree u_tree (
		.pp1       (q_pp1),
		.pp2       (q_pp2),
		.pp3       (q_pp3),
		.pp4       (q_pp4),
		.pp5       (q_pp5),
		.pp6       (q_pp6),
		.signs     (q_signs),
		.sum_row   (sum_row),
		.carry_row (carry_row)
	);

	assign q_ready = !out_valid || out_ready;
	assign take    = q_valid && q_ready;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
		end else if (q_ready) begin
			out_valid <= q_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (take)
			product <= sum_row + carry_row;    // final carry-propagate add, mod 2^20
	end

	a_product_hold: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid && !out_ready |=> out_valid && $stable(product));

endmodule

//--- verilog/dadda_tree.sv
module dadda_tree
	import mult_pkg::*;
(
	input  pp_t      pp1,
	input  pp_t      pp2,
	input  pp_t      pp3,
	input  pp_t      pp4,
	input  pp_t      pp5,
	input  pp_last_t pp6,
	input  signs_t   signs,
	output product_t sum_row,
	output product_t carry_row
);

	pp_t rows [PP_ROWS];

	assign rows[0] = pp1;
	assign rows[1] = pp2;
	assign rows[2] = pp3;
	assign rows[3] = pp4;
	assign rows[4] = pp5;

	always_comb begin
		logic [PP_ROWS:0] dots [PROD_W];        // bits stacked in each column
		logic [PP_ROWS:0] next_dots [PROD_W];
		int               height [PROD_W];
		int               next_height [PROD_W];
		int               rd;
		int               lim;
		logic             a;
		logic             b;
		logic             c;

		rd  = 0;
		lim = 0;
		a   = 1'b0;
		b   = 1'b0;
		c   = 1'b0;
		for (int j = 0; j < PROD_W; j++) begin
			dots[j]        = '0;
			next_dots[j]   = '0;
			height[j]      = 0;
			next_height[j] = 0;
		end

		// full rows at weight 2i, each with its +1 at the row lsb
		for (int i = 0; i < PP_ROWS; i++) begin
			for (int k = 0; k < PP_W; k++) begin
				dots[2*i+k][height[2*i+k]] = rows[i][k];
				height[2*i+k]++;
			end
			dots[2*i][height[2*i]] = signs[i];
			height[2*i]++;
		end

		for (int k = 0; k < PP_LAST_W; k++) begin
			dots[2*PP_ROWS+k][height[2*PP_ROWS+k]] = pp6[k];
			height[2*PP_ROWS+k]++;
		end

		// sign extension folded into constants, first row gets s s ~s
		dots[PP_W][height[PP_W]] = signs[0];
		height[PP_W]++;
		dots[PP_W+1][height[PP_W+1]] = signs[0];
		height[PP_W+1]++;
		dots[PP_W+2][height[PP_W+2]] = ~signs[0];
		height[PP_W+2]++;
		for (int i = 1; i < PP_ROWS; i++) begin
			dots[PP_W+2*i][height[PP_W+2*i]] = ~signs[i];   // then a 1 above each ~s
			height[PP_W+2*i]++;
			if (PP_W + 2*i + 1 < PROD_W) begin
				dots[PP_W+2*i+1][height[PP_W+2*i+1]] = 1'b1;
				height[PP_W+2*i+1]++;
			end
		end

		// heights 6 to 4 to 3 to 2
		for (int stg = 0; stg < 3; stg++) begin
			lim = 4 - stg;
			for (int j = 0; j < PROD_W; j++) begin
				next_dots[j]   = '0;
				next_height[j] = 0;
			end
			for (int j = 0; j < PROD_W; j++) begin
				rd = 0;
				for (int n = 0; n < PP_ROWS; n++) begin
					if (next_height[j] + height[j] - rd > lim) begin
						a = dots[j][rd];
						b = dots[j][rd+1];
						if (next_height[j] + height[j] - rd == lim + 1) begin
							c  = 1'b0;                // half adder is enough
							rd = rd + 2;
						end else begin
							c  = dots[j][rd+2];
							rd = rd + 3;
						end
						next_dots[j][next_height[j]] = a ^ b ^ c;
						next_height[j]++;
						if (j + 1 < PROD_W) begin    // carry out of the msb is dropped
							next_dots[j+1][next_height[j+1]] = (a & b) | (c & (a ^ b));
							next_height[j+1]++;
						end
					end
				end
				for (int k = 0; k <= PP_ROWS; k++) begin
					if (k >= rd && k < height[j]) begin
						next_dots[j][next_height[j]] = dots[j][k];
						next_height[j]++;
					end
				end
			end
			dots   = next_dots;
			height = next_height;
		end

		for (int j = 0; j < PROD_W; j++) begin
			sum_row[j]   = dots[j][0];
			carry_row[j] = dots[j][1];
		end
	end

endmodule

//--- verilog/pp_fifo.sv
module pp_fifo
	import mult_pkg::*;
(
	input  logic     clk,
	input  logic     arst_n,
	input  logic     in_valid,
	output logic     in_ready,
	input  pp_t      in_pp1,
	input  pp_t      in_pp2,
	input  pp_t      in_pp3,
	input  pp_t      in_pp4,
	input  pp_t      in_pp5,
	input  pp_last_t in_pp6,
	input  signs_t   in_signs,
	output logic     out_valid,
	input  logic     out_ready,
	output pp_t      out_pp1,
	output pp_t      out_pp2,
	output pp_t      out_pp3,
	output pp_t      out_pp4,
	output pp_t      out_pp5,
	output pp_last_t out_pp6,
	output signs_t   out_signs
);

	// one entry holds a whole bundle
	logic [PP_ROWS*PP_W+PP_LAST_W+PP_ROWS-1:0] mem [FIFO_DEPTH];

	logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
	logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
	logic [$clog2(FIFO_DEPTH):0]   count;
	logic                          push;
	logic                          pop;

	assign in_ready  = (count != FIFO_DEPTH) || out_ready;   // full but being read is ok
	assign out_valid = (count != '0);                        // no fall-through path
	assign push      = in_valid && in_ready;
	assign pop       = out_valid && out_ready;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;     // wraps at the power-of-two depth
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= {in_pp1, in_pp2, in_pp3, in_pp4, in_pp5, in_pp6, in_signs};
	end

	assign {out_pp1, out_pp2, out_pp3, out_pp4, out_pp5, out_pp6, out_signs} = mem[rd_ptr];

	// a write into a full queue or a read of an empty one drives the count past the depth
	a_count_range: assert property (@(posedge clk) disable iff (!arst_n)
		count <= FIFO_DEPTH);

	// pointers meet only when the queue is empty or full
	a_ptr_match: assert property (@(posedge clk) disable iff (!arst_n)
		(wr_ptr == rd_ptr) == ((count == '0) || (count == FIFO_DEPTH)));

endmodule

//--- verilog/pp_stage.sv
module pp_stage
	import mult_pkg::*;
(
	input  logic     clk,
	input  logic     arst_n,
	input  operand_t a_in,
	input  operand_t b_in,
	input  logic     in_valid,
	output logic     in_ready,
	output logic     pp_valid,
	input  logic     pp_ready,
	output pp_t      pp1,
	output pp_t      pp2,
	output pp_t      pp3,
	output pp_t      pp4,
	output pp_t      pp5,
	output pp_last_t pp6,
	output signs_t   signs
);

	pp_t      enc_pp1, enc_pp2, enc_pp3, enc_pp4, enc_pp5;
	pp_last_t enc_pp6;
	signs_t   enc_signs;
	logic     load;

	booth u_booth (
		.a     (a_in),
		.b     (b_in),
		.pp1   (enc_pp1),
		.pp2   (enc_pp2),
		.pp3   (enc_pp3),
		.pp4   (enc_pp4),
		.pp5   (enc_pp5),
		.pp6   (enc_pp6),
		.signs (enc_signs)
	);

	assign in_ready = !pp_valid || pp_ready;    // empty or draining this cycle
	assign load     = in_valid && in_ready;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pp_valid <= 1'b0;
		end else if (in_ready) begin
			pp_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			pp1   <= enc_pp1;
			pp2   <= enc_pp2;
			pp3   <= enc_pp3;
			pp4   <= enc_pp4;
			pp5   <= enc_pp5;
			pp6   <= enc_pp6;
			signs <= enc_signs;
		end
	end

	// a stalled bundle must not change under the queue
	a_pp_hold: assert property (@(posedge clk) disable iff (!arst_n)
		pp_valid && !pp_ready |=>
		pp_valid && $stable({pp1, pp2, pp3, pp4, pp5, pp6, signs}));

endmodule

//--- verilog/booth.sv
module booth
	import mult_pkg::*;
(
	input  operand_t a,
	input  operand_t b,
	output pp_t      pp1,
	output pp_t      pp2,
	output pp_t      pp3,
	output pp_t      pp4,
	output pp_t      pp5,
	output pp_last_t pp6,
	output signs_t   signs
);

	logic [OP_W+2:0] b_ext;    // two zeros above b, one below

	// radix-4 digit select for one overlapping group
	//   000, 111 give 0
	//   001, 010 give +a
	//   011 gives +2a, 100 gives -2a
	//   101, 110 give -a
	function automatic pp_t encode(input logic [2:0] grp, input operand_t op);
		pp_t row;
		case (grp)
			3'b001, 3'b010: row = {1'b0, op};
			3'b011:         row = {op, 1'b0};
			3'b100:         row = ~{op, 1'b0};
			3'b101, 3'b110: row = ~{1'b0, op};
			3'b111:         row = '1;            // minus zero, the flag wraps it back to 0
			default:        row = '0;
		endcase
		return row;
	endfunction

	assign b_ext = {2'b00, b, 1'b0};

	assign pp1 = encode(b_ext[2:0], a);
	assign pp2 = encode(b_ext[4:2], a);
	assign pp3 = encode(b_ext[6:4], a);
	assign pp4 = encode(b_ext[8:6], a);
	assign pp5 = encode(b_ext[10:8], a);

	// top group is {0, 0, b[9]} so only 0 or +a can occur
	always_comb begin
		case (b_ext[12:10])
			3'b001:  pp6 = a;
			default: pp6 = '0;
		endcase
	end

	// top bit of each group marks a negated row
	assign signs = {b[9], b[7], b[5], b[3], b[1]};

endmodule

//--- verilog/mult_pkg.sv
package mult_pkg;

	localparam int OP_W       = 10;           // operand width
	localparam int PP_W       = OP_W + 1;     // room for the doubled operand
	localparam int PP_LAST_W  = OP_W;         // sixth row is 0 or +a only
	localparam int PP_ROWS    = 5;            // rows that can be negated
	localparam int PROD_W     = 2 * OP_W;     // full unsigned product
	localparam int FIFO_DEPTH = 2;            // partial-product queue entries

	// one multiplier operand
	typedef logic [OP_W-1:0] operand_t;

	// full partial-product row, negative rows kept bit-inverted
	typedef logic [PP_W-1:0] pp_t;

	// last row from the zero-extended top of b
	typedef logic [PP_LAST_W-1:0] pp_last_t;

	// one negation flag per full row, flag i is b[2i+1]
	typedef logic [PP_ROWS-1:0] signs_t;

	typedef logic [PROD_W-1:0] product_t;

endpackage
